//--- filelist.f
common/tlb_pkg.sv
tlb/tlb_lutram.sv
tlb/tlb_entry.sv
tlb/tlb_invalidate.sv
hdl/tlb_top.sv
dv/tlb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tlb_tb \
    --Mdir obj_dir -o tlb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tlb_sim)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- dv/tlb_tb.sv
`timescale 1ns/1ns

module tlb_tb;
    import tlb_pkg::*;

    // rough cycle budget per test, used for the hang limit
    localparam int LEN_RESET = 6;
    localparam int LEN_IDLE = 12;
    localparam int LEN_FILL = 64;
    localparam int LEN_SEARCH = 160;
    localparam int LEN_INV_OPS = 8 * 100;
    localparam int LEN_HELD = 135;
    localparam int LEN_RANDOM = 550;
    localparam int LEN_TOTAL = LEN_RESET + LEN_IDLE + LEN_FILL + LEN_SEARCH +
                               LEN_INV_OPS + LEN_HELD + LEN_RANDOM;
    localparam int TIMEOUT = (LEN_TOTAL * 3) / 2;

    logic            clk;
    logic            rst;
    logic            s0_fetch;
    tlb_search_req_t s0_req;
    tlb_search_rsp_t s0_rsp;
    logic            s1_fetch;
    tlb_search_req_t s1_req;
    tlb_search_rsp_t s1_rsp;
    logic            we;
    logic [4:0]      w_index;
    tlb_entry_t      w_entry;
    logic [4:0]      r_index;
    tlb_entry_t      r_entry;
    logic            inv_valid;
    logic            inv_ready;
    tlb_inv_t        inv_req;

    // shadow copy of the table, e included
    tlb_entry_t      model [TLB_NUM];
    integer          seed = 57921;
    int              cyc = 0;

    // expected responses, tagged with the cycle of their fetch
    tlb_search_rsp_t exp_q0 [$];
    tlb_search_rsp_t exp_q1 [$];
    int              tag_q0 [$];
    int              tag_q1 [$];

    tlb_top #(
        .NSET(TLB_NSET)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .s0_fetch (s0_fetch),
        .s0_req   (s0_req),
        .s0_rsp   (s0_rsp),
        .s1_fetch (s1_fetch),
        .s1_req   (s1_req),
        .s1_rsp   (s1_rsp),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_index  (r_index),
        .r_entry  (r_entry),
        .inv_valid(inv_valid),
        .inv_ready(inv_ready),
        .inv_req  (inv_req)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_with_error(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "test stopped");
    endtask

    // hang guard
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            stop_with_error("timeout, the run hung and never reached its end");
        end
    end

    task automatic check_rsp(string name, tlb_search_rsp_t got, tlb_search_rsp_t exp);
        logic ok;
        // on a miss only found counts
        ok = exp.found ? (got === exp) : (got.found === 1'b0);
        if (!ok) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_error("search response differs from the reference");
        end
    endtask

    task automatic check_entry(string name, tlb_entry_t got, tlb_entry_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stop_with_error("read port differs from the shadow table");
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            stop_with_error("single bit check failed");
        end
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    // expected lookup: only the set named by vppn[2:0], highest way wins
    function automatic tlb_search_rsp_t ref_search(tlb_search_req_t q);
        tlb_search_rsp_t r;
        tlb_entry_t      ent;
        logic            hit;
        logic            odd;
        int              idx;
        r = '0;
        for (int w = 0; w < TLB_NWAY; w++) begin
            idx = w * TLB_NSET + int'(q.vppn[2:0]);
            ent = model[idx];
            if (ent.ps == PS_4K) begin
                hit = ent.vppn == q.vppn;
            end else begin
                hit = ent.vppn[18:9] == q.vppn[18:9];
            end
            hit = hit && ent.e && (ent.g || ent.asid == q.asid);
            if (hit) begin
                // 4M pages take the half from vppn bit 8
                odd = (ent.ps == PS_4K) ? q.odd_page : q.vppn[8];
                r.found = 1'b1;
                r.index = 5'(idx);
                r.ps = ent.ps;
                r.ppn = odd ? ent.ppn1 : ent.ppn0;
                r.v = odd ? ent.v1 : ent.v0;
                r.d = odd ? ent.d1 : ent.d0;
                r.mat = odd ? ent.mat1 : ent.mat0;
                r.plv = odd ? ent.plv1 : ent.plv0;
            end
        end
        return r;
    endfunction

    // INVTLB op table
    function automatic logic inv_hits(tlb_inv_t q, tlb_entry_t ent);
        logic asid_eq;
        logic vpn_eq;
        logic hit;
        asid_eq = ent.asid == q.asid;
        vpn_eq = (ent.ps == PS_4K) ? (ent.vppn == q.vpn) : (ent.vppn[18:10] == q.vpn[18:10]);
        case (q.op)
            INV_ALL0, INV_ALL1: hit = 1'b1;
            INV_GLOBAL:         hit = ent.g;
            INV_NONGLOBAL:      hit = !ent.g;
            INV_ASID:           hit = !ent.g && asid_eq;
            INV_ASID_VA:        hit = !ent.g && asid_eq && vpn_eq;
            INV_GASID_VA:       hit = (ent.g || asid_eq) && vpn_eq;
            default:            hit = 1'b0;
        endcase
        return hit;
    endfunction

    function automatic void apply_inv(tlb_inv_t q);
        for (int i = 0; i < TLB_NUM; i++) begin
            if (inv_hits(q, model[i])) begin
                model[i].e = 1'b0;
            end
        end
    endfunction

    // few tag patterns, so tags collide and ways duplicate
    function automatic tlb_entry_t make_entry(int idx);
        tlb_entry_t  ent;
        logic [31:0] r;
        logic [31:0] p0;
        logic [31:0] p1;
        r = next_random();
        p0 = next_random();
        p1 = next_random();
        ent.vppn = {(r[0] ? 9'h0a5 : 9'h15a), (r[1] ? 7'h11 : 7'h6c), 3'(idx)};
        ent.ps = r[2] ? PS_4M : PS_4K;
        ent.g = r[3] & r[4];
        ent.asid = {8'd0, r[6:5]};
        ent.e = r[8:7] != 2'b00;
        ent.ppn0 = p0[19:0];
        ent.plv0 = p0[21:20];
        ent.mat0 = p0[23:22];
        ent.d0 = p0[24];
        ent.v0 = p0[25];
        ent.ppn1 = p1[19:0];
        ent.plv1 = p1[21:20];
        ent.mat1 = p1[23:22];
        ent.d1 = p1[24];
        ent.v1 = p1[25];
        return ent;
    endfunction

    // request aimed at a table entry, then bent a little
    function automatic tlb_search_req_t pick_request();
        tlb_search_req_t q;
        tlb_entry_t      ent;
        logic [31:0]     r;
        r = next_random();
        ent = model[r[4:0]];
        q.vppn = ent.vppn;
        q.odd_page = r[5];
        q.asid = r[6] ? ent.asid : {8'd0, r[8:7]};
        // other half of a 4M page
        if (r[9]) begin
            q.vppn[8] = ~q.vppn[8];
        end
        // inside a 4M page but off a 4K one
        if (r[10] & r[11]) begin
            q.vppn[4] = ~q.vppn[4];
        end
        if (r[12] & r[13] & r[14]) begin
            q.vppn[16] = ~q.vppn[16];
        end
        return q;
    endfunction

    function automatic tlb_search_req_t any_request();
        tlb_search_req_t q;
        logic [31:0]     r;
        r = next_random();
        q.vppn = r[18:0];
        q.odd_page = r[19];
        q.asid = r[29:20];
        return q;
    endfunction

    function automatic tlb_inv_t pick_inv(logic [4:0] op);
        tlb_inv_t    q;
        tlb_entry_t  ent;
        logic [31:0] r;
        r = next_random();
        ent = model[r[4:0]];
        q.op = op;
        q.asid = r[5] ? ent.asid : {8'd0, r[7:6]};
        q.vpn = ent.vppn;
        // bit 9 splits 4K from 4M matching
        if (r[8]) begin
            q.vpn[9] = ~q.vpn[9];
        end
        if (r[9] & r[10]) begin
            q.vpn[14] = ~q.vpn[14];
        end
        return q;
    endfunction

    // falling edge, strobes drop unless driven again
    task automatic tick();
        @(negedge clk);
        we = 1'b0;
        s0_fetch = 1'b0;
        s1_fetch = 1'b0;
    endtask

    // expectation taken before any write of the same cycle
    task automatic drive_search(int port, tlb_search_req_t q);
        if (port == 0) begin
            s0_fetch = 1'b1;
            s0_req = q;
            exp_q0.push_back(ref_search(q));
            tag_q0.push_back(cyc);
        end else begin
            s1_fetch = 1'b1;
            s1_req = q;
            exp_q1.push_back(ref_search(q));
            tag_q1.push_back(cyc);
        end
    endtask

    task automatic drive_write(int idx, tlb_entry_t ent);
        we = 1'b1;
        w_index = 5'(idx);
        w_entry = ent;
        model[idx] = ent;
    endtask

    task automatic write_entry(int idx, tlb_entry_t ent);
        tick();
        drive_write(idx, ent);
    endtask

    task automatic search_pair(tlb_search_req_t a, tlb_search_req_t b);
        tick();
        drive_search(0, a);
        drive_search(1, b);
    endtask

    task automatic load_table();
        for (int i = 0; i < TLB_NUM; i++) begin
            write_entry(i, make_entry(i));
        end
    endtask

    // r_entry is combinational, sampled mid low phase
    task automatic readback_all();
        for (int i = 0; i < TLB_NUM; i++) begin
            tick();
            r_index = 5'(i);
            #1;
            check_entry("r_entry", r_entry, model[i]);
        end
    endtask

    // ready low for 32 falling edges, back on the 33rd
    task automatic finish_sweep();
        for (int k = 1; k <= 33; k++) begin
            tick();
            if (k == 1) begin
                inv_valid = 1'b0;
            end
            check_bit("inv_ready", inv_ready, k == 33);
        end
    endtask

    task automatic run_inv(tlb_inv_t q);
        int n;
        tick();
        inv_valid = 1'b1;
        inv_req = q;
        n = 0;
        while (!inv_ready) begin
            n++;
            if (n > 40) begin
                stop_with_error("inv_ready stayed low, the request was never accepted");
            end
            tick();
        end
        apply_inv(q);
        finish_sweep();
    endtask

    // response checker, one cycle after each fetch
    always @(negedge clk) begin
        while (tag_q0.size() > 0 && tag_q0[0] < cyc) begin
            check_rsp("s0_rsp", s0_rsp, exp_q0[0]);
            void'(exp_q0.pop_front());
            void'(tag_q0.pop_front());
        end
        while (tag_q1.size() > 0 && tag_q1[0] < cyc) begin
            check_rsp("s1_rsp", s1_rsp, exp_q1[0]);
            void'(exp_q1.pop_front());
            void'(tag_q1.pop_front());
        end
    end

    initial begin
        tlb_entry_t      ent;
        tlb_search_req_t q;
        tlb_inv_t        ia;
        tlb_inv_t        ib;
        logic [31:0]     r;
        rst = 1'b1;
        s0_fetch = 1'b0;
        s0_req = '0;
        s1_fetch = 1'b0;
        s1_req = '0;
        we = 1'b0;
        w_index = '0;
        w_entry = '0;
        r_index = '0;
        inv_valid = 1'b0;
        inv_req = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // empty table after reset
        check_bit("inv_ready", inv_ready, 1'b1);
        check_rsp("s0_rsp", s0_rsp, '0);
        check_rsp("s1_rsp", s1_rsp, '0);
        repeat (10) search_pair(any_request(), any_request());

        // all 32 written, read back
        load_table();
        readback_all();

        // same tag in ways 1 and 3 of set 5, way 3 must win
        load_table();
        ent = make_entry(13);
        ent.e = 1'b1;
        ent.g = 1'b1;
        write_entry(13, ent);
        ent.ppn0 = ~ent.ppn0;
        ent.ppn1 = ~ent.ppn1;
        write_entry(29, ent);
        q.vppn = ent.vppn;
        q.odd_page = 1'b1;
        q.asid = 10'h3ff;
        search_pair(q, q);
        repeat (120) search_pair(pick_request(), pick_request());

        // ops 0 to 6 plus undefined op 7
        for (int op = 0; op < 8; op++) begin
            load_table();
            run_inv(pick_inv(5'(op)));
            readback_all();
        end

        // second request held through a sweep, writes land mid sweep
        load_table();
        ia = '0;
        ia.op = INV_ALL0;
        ib = pick_inv(INV_GLOBAL);
        tick();
        inv_valid = 1'b1;
        inv_req = ia;
        check_bit("inv_ready", inv_ready, 1'b1);
        apply_inv(ia);
        for (int k = 1; k <= 33; k++) begin
            tick();
            inv_req = ib;
            check_bit("inv_ready", inv_ready, k == 33);
            // same edge as the clear of index 3
            if (k == 4) begin
                ent = make_entry(3);
                ent.e = 1'b1;
                // non global, so the INV_GLOBAL sweep after it leaves the entry
                ent.g = 1'b0;
                drive_write(3, ent);
            end
            // index 5 already swept
            if (k == 10) begin
                ent = make_entry(5);
                ent.e = 1'b1;
                drive_write(5, ent);
            end
        end
        apply_inv(ib);
        finish_sweep();
        readback_all();

        // random mix, an invalidation every 50 steps
        for (int i = 0; i < 300; i++) begin
            if (i % 50 == 49) begin
                r = next_random();
                run_inv(pick_inv({1'b0, r[3:0]}));
            end else begin
                tick();
                r = next_random();
                if (r[1:0] != 2'b00) begin
                    drive_search(0, pick_request());
                end
                if (r[3:2] != 2'b00) begin
                    drive_search(1, pick_request());
                end
                if (r[5:4] == 2'b00) begin
                    drive_write(int'(r[10:6]), make_entry(int'(r[10:6])));
                end
            end
        end
        readback_all();
        repeat (2) tick();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- hdl/tlb_top.sv
`timescale 1ns/1ns

module tlb_top #(
    parameter int NSET = tlb_pkg::TLB_NSET
) (
    input  logic                          clk,
    input  logic                          rst,

    // search ports
    input  logic                          s0_fetch,
    input  tlb_pkg::tlb_search_req_t      s0_req,
    output tlb_pkg::tlb_search_rsp_t      s0_rsp,
    input  logic                          s1_fetch,
    input  tlb_pkg::tlb_search_req_t      s1_req,
    output tlb_pkg::tlb_search_rsp_t      s1_rsp,

    // software write and read
    input  logic                          we,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] w_index,
    input  tlb_pkg::tlb_entry_t           w_entry,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] r_index,
    output tlb_pkg::tlb_entry_t           r_entry,

    // INVTLB
    input  logic                          inv_valid,
    output logic                          inv_ready,
    input  tlb_pkg::tlb_inv_t             inv_req
);
    import tlb_pkg::*;

    // sweeper to storage
    logic [TLB_IDX_W-1:0] scan_index;
    tlb_entry_t           scan_entry;
    logic                 clr;
    logic [TLB_IDX_W-1:0] clr_index;

    tlb_entry #(
        .NSET(NSET)
    ) u_entry (
        .clk       (clk),
        .rst       (rst),
        .s0_fetch  (s0_fetch),
        .s0_req    (s0_req),
        .s0_rsp    (s0_rsp),
        .s1_fetch  (s1_fetch),
        .s1_req    (s1_req),
        .s1_rsp    (s1_rsp),
        .we        (we),
        .w_index   (w_index),
        .w_entry   (w_entry),
        .r_index   (r_index),
        .r_entry   (r_entry),
        .scan_index(scan_index),
        .scan_entry(scan_entry),
        .clr       (clr),
        .clr_index (clr_index)
    );

    tlb_invalidate u_inv (
        .clk       (clk),
        .rst       (rst),
        .inv_valid (inv_valid),
        .inv_ready (inv_ready),
        .inv_req   (inv_req),
        .scan_index(scan_index),
        .scan_entry(scan_entry),
        .clr       (clr),
        .clr_index (clr_index)
    );

endmodule

//--- tlb/tlb_invalidate.sv
`timescale 1ns/1ns

module tlb_invalidate (
    input  logic                          clk,
    input  logic                          rst,

    // request, valid/ready
    input  logic                          inv_valid,
    output logic                          inv_ready,
    input  tlb_pkg::tlb_inv_t             inv_req,

    // walk over the entry array
    output logic [tlb_pkg::TLB_IDX_W-1:0] scan_index,
    input  tlb_pkg::tlb_entry_t           scan_entry,
    output logic                          clr,
    output logic [tlb_pkg::TLB_IDX_W-1:0] clr_index
);
    import tlb_pkg::*;

    typedef enum logic {
        IDLE,
        SWEEP
    } state_t;

    state_t               state;
    logic [TLB_IDX_W-1:0] idx;
    tlb_inv_t             req_q;
    logic                 asid_eq;
    logic                 vpn_eq;
    logic                 hit;

    // ready only while idle
    assign inv_ready = state == IDLE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (inv_valid) begin
                        state <= SWEEP;
                        idx <= '0;
                    end
                end
                SWEEP: begin
                    // one entry per cycle, 0 up to 31
                    idx <= idx + 1'b1;
                    if (idx == TLB_IDX_W'(TLB_NUM - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latch the op at the handshake
    always_ff @(posedge clk) begin
        if (inv_ready && inv_valid) begin
            req_q <= inv_req;
        end
    end

    assign scan_index = idx;
    assign clr_index = idx;

    assign asid_eq = scan_entry.asid == req_q.asid;

    // 4M page compares the upper vpn bits only
    assign vpn_eq = (scan_entry.ps == PS_4K) ? (scan_entry.vppn == req_q.vpn) :
                    (scan_entry.vppn[18:10] == req_q.vpn[18:10]);

    // op table
    always_comb begin
        case (req_q.op)
            INV_ALL0,
            INV_ALL1:      hit = 1'b1;
            INV_GLOBAL:    hit = scan_entry.g;
            INV_NONGLOBAL: hit = !scan_entry.g;
            INV_ASID:      hit = !scan_entry.g && asid_eq;
            INV_ASID_VA:   hit = !scan_entry.g && asid_eq && vpn_eq;
            INV_GASID_VA:  hit = (scan_entry.g || asid_eq) && vpn_eq;
            // undefined op, sweep runs but nothing clears
            default:       hit = 1'b0;
        endcase
    end

    assign clr = (state == SWEEP) && hit;

endmodule

//--- tlb/tlb_entry.sv
`timescale 1ns/1ns

module tlb_entry #(
    parameter int NSET = tlb_pkg::TLB_NSET
) (
    input  logic                            clk,
    input  logic                            rst,

    // search port 0, instruction side
    input  logic                            s0_fetch,
    input  tlb_pkg::tlb_search_req_t        s0_req,
    output tlb_pkg::tlb_search_rsp_t        s0_rsp,

    // search port 1, data side
    input  logic                            s1_fetch,
    input  tlb_pkg::tlb_search_req_t        s1_req,
    output tlb_pkg::tlb_search_rsp_t        s1_rsp,

    // software write, lands on the edge
    input  logic                            we,
    input  logic [tlb_pkg::TLB_IDX_W-1:0]   w_index,
    input  tlb_pkg::tlb_entry_t             w_entry,

    // software read, same cycle
    input  logic [tlb_pkg::TLB_IDX_W-1:0]   r_index,
    output tlb_pkg::tlb_entry_t             r_entry,

    // sweeper access
    input  logic [tlb_pkg::TLB_IDX_W-1:0]   scan_index,
    output tlb_pkg::tlb_entry_t             scan_entry,
    input  logic                            clr,
    input  logic [tlb_pkg::TLB_IDX_W-1:0]   clr_index
);
    import tlb_pkg::*;

    localparam int SET_W = $clog2(NSET);
    localparam int WAY_W = $clog2(TLB_NWAY);

    // both search ports folded into arrays, index 0 is s0
    tlb_search_req_t     req [2];
    logic [1:0]          fetch;
    tlb_search_rsp_t     rsp [2];

    // per way storage outputs
    tlb_entry_t          srch_ent [2][TLB_NWAY];
    tlb_entry_t          rd_ent [TLB_NWAY];
    tlb_entry_t          sc_ent [TLB_NWAY];
    logic [TLB_NWAY-1:0] way_we;

    // authoritative existence bits
    logic [TLB_NUM-1:0]  e_bits;

    assign req[0] = s0_req;
    assign req[1] = s1_req;
    assign fetch = {s1_fetch, s0_fetch};
    assign s0_rsp = rsp[0];
    assign s1_rsp = rsp[1];

    // way decode from upper index bits
    always_comb begin
        for (int w = 0; w < TLB_NWAY; w++) begin
            way_we[w] = we && (w_index[TLB_IDX_W-1 -: WAY_W] == WAY_W'(w));
        end
    end

    for (genvar w = 0; w < TLB_NWAY; w++) begin : g_way
        tlb_lutram #(
            .DEPTH(NSET)
        ) u_ram (
            .clk       (clk),
            .inst_addr (req[0].vppn[SET_W-1:0]),
            .inst_entry(srch_ent[0][w]),
            .data_addr (req[1].vppn[SET_W-1:0]),
            .data_entry(srch_ent[1][w]),
            .raddr     (r_index[SET_W-1:0]),
            .rdata     (rd_ent[w]),
            .scan_addr (scan_index[SET_W-1:0]),
            .scan_data (sc_ent[w]),
            .we        (way_we[w]),
            .waddr     (w_index[SET_W-1:0]),
            .wdata     (w_entry)
        );
    end

    // clear first, so a write on the same index wins
    always_ff @(posedge clk) begin
        if (rst) begin
            e_bits <= '0;
        end else begin
            if (clr) begin
                e_bits[clr_index] <= 1'b0;
            end
            if (we) begin
                e_bits[w_index] <= w_entry.e;
            end
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic [TLB_NWAY-1:0] match_d;
        logic [TLB_NWAY-1:0] match_q;
        logic [TLB_NWAY-1:0] odd_d;
        logic [TLB_NWAY-1:0] odd_q;
        logic [SET_W-1:0]    set_d;
        logic [SET_W-1:0]    set_q;
        tlb_entry_t          way_q [TLB_NWAY];
        logic [WAY_W-1:0]    win;
        tlb_entry_t          hit_ent;
        tlb_search_rsp_t     prsp;

        // set comes straight from the low vppn bits
        assign set_d = req[p].vppn[SET_W-1:0];

        // compare all ways of the set
        always_comb begin
            tlb_entry_t ent;
            logic       vpn_eq;
            for (int w = 0; w < TLB_NWAY; w++) begin
                ent = srch_ent[p][w];
                if (ent.ps == PS_4K) begin
                    vpn_eq = ent.vppn == req[p].vppn;
                    odd_d[w] = req[p].odd_page;
                end else begin
                    // 4M page, low vppn bits are inside the page
                    vpn_eq = ent.vppn[VPPN_W-1:HUGE_ODD_BIT+1] ==
                             req[p].vppn[VPPN_W-1:HUGE_ODD_BIT+1];
                    odd_d[w] = req[p].vppn[HUGE_ODD_BIT];
                end
                match_d[w] = e_bits[{WAY_W'(w), set_d}] && vpn_eq &&
                             (ent.g || ent.asid == req[p].asid);
            end
        end

        // per way hit vector of the last fetch
        always_ff @(posedge clk) begin
            if (rst) begin
                match_q <= '0;
            end else if (fetch[p]) begin
                match_q <= match_d;
            end
        end

        // hold the looked-up set so back to back fetches keep their result
        always_ff @(posedge clk) begin
            if (fetch[p]) begin
                set_q <= set_d;
                odd_q <= odd_d;
                for (int w = 0; w < TLB_NWAY; w++) begin
                    way_q[w] <= srch_ent[p][w];
                end
            end
        end

        // highest way wins
        always_comb begin
            win = '0;
            for (int w = 0; w < TLB_NWAY; w++) begin
                if (match_q[w]) begin
                    win = WAY_W'(w);
                end
            end
        end

        assign hit_ent = way_q[win];

        // pick even or odd half of the winner
        always_comb begin
            prsp.found = |match_q;
            prsp.index = {win, set_q};
            prsp.ps = hit_ent.ps;
            if (odd_q[win]) begin
                prsp.ppn = hit_ent.ppn1;
                prsp.v = hit_ent.v1;
                prsp.d = hit_ent.d1;
                prsp.mat = hit_ent.mat1;
                prsp.plv = hit_ent.plv1;
            end else begin
                prsp.ppn = hit_ent.ppn0;
                prsp.v = hit_ent.v0;
                prsp.d = hit_ent.d0;
                prsp.mat = hit_ent.mat0;
                prsp.plv = hit_ent.plv0;
            end
        end

        assign rsp[p] = prsp;
    end

    // read ports, storage word with live e merged in
    always_comb begin
        r_entry = rd_ent[r_index[TLB_IDX_W-1 -: WAY_W]];
        r_entry.e = e_bits[r_index];
    end

    always_comb begin
        scan_entry = sc_ent[scan_index[TLB_IDX_W-1 -: WAY_W]];
        scan_entry.e = e_bits[scan_index];
    end

endmodule

//--- tlb/tlb_lutram.sv
`timescale 1ns/1ns

module tlb_lutram #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,

    // search reads, instruction side and data side
    input  logic [$clog2(DEPTH)-1:0] inst_addr,
    output tlb_pkg::tlb_entry_t      inst_entry,
    input  logic [$clog2(DEPTH)-1:0] data_addr,
    output tlb_pkg::tlb_entry_t      data_entry,

    // software read
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output tlb_pkg::tlb_entry_t      rdata,

    // sweeper read
    input  logic [$clog2(DEPTH)-1:0] scan_addr,
    output tlb_pkg::tlb_entry_t      scan_data,

    // single write port
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  tlb_pkg::tlb_entry_t      wdata
);
    import tlb_pkg::*;

    // one way worth of entries
    // e is kept here too but the flop copy in tlb_entry wins
    tlb_entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // async reads, maps to distributed ram
    assign inst_entry = mem[inst_addr];
    assign data_entry = mem[data_addr];
    assign rdata = mem[raddr];
    assign scan_data = mem[scan_addr];

endmodule

//--- common/tlb_pkg.sv
package tlb_pkg;

    // geometry, 4 ways x 8 sets
    localparam int TLB_NWAY = 4;
    localparam int TLB_NSET = 8;
    localparam int TLB_NUM = TLB_NWAY * TLB_NSET;

    // index = {way, set}, way in the two upper bits
    localparam int TLB_IDX_W = $clog2(TLB_NUM);

    // field widths
    localparam int VPPN_W = 19;
    localparam int PPN_W = 20;
    localparam int ASID_W = 10;

    // page size codes
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd21;

    // vppn starts at va bit 13
    // so a 4M page picks its half with vppn bit 8
    localparam int HUGE_ODD_BIT = int'(PS_4M) - 13;

    // INVTLB op codes
    localparam logic [4:0] INV_ALL0 = 5'd0;
    localparam logic [4:0] INV_ALL1 = 5'd1;
    localparam logic [4:0] INV_GLOBAL = 5'd2;
    localparam logic [4:0] INV_NONGLOBAL = 5'd3;
    localparam logic [4:0] INV_ASID = 5'd4;
    localparam logic [4:0] INV_ASID_VA = 5'd5;
    localparam logic [4:0] INV_GASID_VA = 5'd6;

    // one stored entry, tag part first
    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic [5:0]        ps;
        logic              g;
        logic [ASID_W-1:0] asid;
        logic              e;
        // even page
        logic [PPN_W-1:0]  ppn0;
        logic [1:0]        plv0;
        logic [1:0]        mat0;
        logic              d0;
        logic              v0;
        // odd page
        logic [PPN_W-1:0]  ppn1;
        logic [1:0]        plv1;
        logic [1:0]        mat1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    // lookup request from fetch or lsu
    typedef struct packed {
        logic [VPPN_W-1:0] vppn;
        logic              odd_page;
        logic [ASID_W-1:0] asid;
    } tlb_search_req_t;

    // lookup result, one cycle after fetch
    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic [5:0]           ps;
        logic [PPN_W-1:0]     ppn;
        logic                 v;
        logic                 d;
        logic [1:0]           mat;
        logic [1:0]           plv;
    } tlb_search_rsp_t;

    // INVTLB request
    typedef struct packed {
        logic [4:0]        op;
        logic [ASID_W-1:0] asid;
        logic [VPPN_W-1:0] vpn;
    } tlb_inv_t;

endpackage
